// ==== include/legalizer_params.svh ====
`ifndef LEGALIZER_PARAMS_SVH
`define LEGALIZER_PARAMS_SVH

// Bus data width in bits
`define LEG_DATA_WIDTH 32
// Bytes per beat
`define LEG_STRB_WIDTH (`LEG_DATA_WIDTH / 8)
// Byte-in-beat offset bits
`define LEG_OFFSET_WIDTH 2

// Address and length width
`define LEG_ADDR_WIDTH 24
// Page offset bits, 1024 byte pages
`define LEG_PAGE_ADDR_WIDTH 10
`define LEG_PAGE_SIZE (1 << `LEG_PAGE_ADDR_WIDTH)

// Transaction id width
`define LEG_ID_WIDTH 4
// Max burst length code, n means 2^n beats
`define LEG_LLEN_WIDTH 3
// AXI len field, beats minus one
`define LEG_AXI_LEN_WIDTH 8

`endif

// ==== logic/legalizer_pkg.sv ====
`default_nettype none

`include "legalizer_params.svh"

package legalizer_pkg;

    // --------------------
    // Options
    // --------------------

    // Limits of one side
    typedef struct packed {
        logic                        reduce_len;
        logic [`LEG_LLEN_WIDTH-1:0] max_llen;
    } side_opt_t;

    // Per transfer options, src drives reads and dst drives writes
    typedef struct packed {
        logic      decouple_rw;
        side_opt_t src;
        side_opt_t dst;
    } leg_opt_t;

    // --------------------
    // Requests
    // --------------------

    // Incoming 1D copy request
    typedef struct packed {
        logic [`LEG_ADDR_WIDTH-1:0] length;
        logic [`LEG_ADDR_WIDTH-1:0] src_addr;
        logic [`LEG_ADDR_WIDTH-1:0] dst_addr;
        logic [`LEG_ID_WIDTH-1:0]   id;
        leg_opt_t                   opt;
    } leg_req_t;

    // One emitted AXI burst, addr always beat aligned
    typedef struct packed {
        logic [`LEG_ID_WIDTH-1:0]      id;
        logic [`LEG_ADDR_WIDTH-1:0]    addr;
        logic [`LEG_AXI_LEN_WIDTH-1:0] len;
    } ax_req_t;

    // Bytes up to a boundary, one extra bit to hold a full page
    typedef logic [`LEG_PAGE_ADDR_WIDTH:0] page_len_t;

    // Address word, seen as page + offset or as beat + byte lane
    typedef union packed {
        struct packed {
            logic [`LEG_ADDR_WIDTH-`LEG_PAGE_ADDR_WIDTH-1:0] page_num;
            logic [`LEG_PAGE_ADDR_WIDTH-1:0]                 page_off;
        } page;
        struct packed {
            logic [`LEG_ADDR_WIDTH-`LEG_OFFSET_WIDTH-1:0] beat_num;
            logic [`LEG_OFFSET_WIDTH-1:0]                 byte_off;
        } beat;
    } addr_view_u;

    // Mutable state of one side
    typedef struct packed {
        logic [`LEG_ADDR_WIDTH-1:0] length;
        addr_view_u                 addr;
        logic                       valid;
    } chan_tf_t;

endpackage

`default_nettype wire

// ==== logic/page_splitter.sv ====
`default_nettype none

`include "legalizer_params.svh"

module page_splitter (
    input  wire legalizer_pkg::addr_view_u addr_i,
    input  wire legalizer_pkg::side_opt_t  opt_i,
    output legalizer_pkg::page_len_t       bytes_to_pb_o
);
    import legalizer_pkg::*;

    // Distance to the end of the 1024 byte page
    page_len_t page_dist;
    // Reduced window size in bytes
    page_len_t burst_size;
    // Position inside the reduced window
    page_len_t burst_off;
    // Distance to the end of the reduced window
    page_len_t burst_dist;

    // --------------------
    // Page boundary
    // --------------------

    // Full page minus offset, gives 1024 on an aligned page
    assign page_dist = page_len_t'(`LEG_PAGE_SIZE) - page_len_t'(addr_i.page.page_off);

    // --------------------
    // Reduced boundary
    // --------------------

    // 2^max_llen beats of STRB bytes each
    assign burst_size = page_len_t'(`LEG_STRB_WIDTH) << opt_i.max_llen;

    // Window is a power of two below the page size,
    // so the page offset alone gives the address modulo
    assign burst_off  = page_len_t'(addr_i.page.page_off) & (burst_size - 1'b1);
    assign burst_dist = burst_size - burst_off;

    // Reduced window always nests inside the page
    assign bytes_to_pb_o = opt_i.reduce_len ? burst_dist : page_dist;

endmodule

`default_nettype wire

// ==== logic/burst_channel.sv ====
`default_nettype none

`include "legalizer_params.svh"

module burst_channel (
    input  wire logic                              clk_i,
    input  wire logic                              arst_n_i,
    input  wire logic                              load_i,
    input  wire logic                              step_i,
    input  wire logic                              clear_i,
    input  wire legalizer_pkg::addr_view_u         load_addr_i,
    input  wire logic [`LEG_ADDR_WIDTH-1:0]       load_len_i,
    input  wire logic [`LEG_ID_WIDTH-1:0]         id_i,
    input  wire legalizer_pkg::side_opt_t          opt_i,
    input  wire legalizer_pkg::page_len_t          bytes_possible_i,
    output legalizer_pkg::page_len_t               bytes_to_pb_o,
    output logic                                   done_o,
    output logic                                   busy_o,
    output legalizer_pkg::ax_req_t                 req_o
);
    import legalizer_pkg::*;

    // Side state, mutated on every step
    chan_tf_t tf_d;
    chan_tf_t tf_q;
    logic     tf_ena;

    // Id held for the whole transfer
    logic [`LEG_ID_WIDTH-1:0] id_q;

    // Bytes of the burst on offer
    page_len_t num_bytes;
    // Bytes touched from the start of the first beat, minus one
    page_len_t beat_span;

    addr_view_u next_addr;
    addr_view_u aligned_addr;

    // --------------------
    // Boundary
    // --------------------
    page_splitter u_splitter (
        .addr_i        (tf_q.addr),
        .opt_i         (opt_i),
        .bytes_to_pb_o (bytes_to_pb_o)
    );

    // Address after the burst on offer
    assign next_addr = addr_view_u'(tf_q.addr + `LEG_ADDR_WIDTH'(num_bytes));

    // --------------------
    // Next state
    // --------------------
    always_comb begin : proc_next_tf
        tf_d   = tf_q;
        done_o = 1'b0;

        if (tf_q.length > `LEG_ADDR_WIDTH'(bytes_possible_i)) begin
            // Cut at the boundary, keep the rest
            num_bytes   = bytes_possible_i;
            tf_d.length = tf_q.length - `LEG_ADDR_WIDTH'(num_bytes);
            tf_d.addr   = next_addr;
        end else begin
            // Rest fits in one burst
            num_bytes  = tf_q.length[`LEG_PAGE_ADDR_WIDTH:0];
            tf_d.valid = 1'b0;
            done_o     = 1'b1;
        end

        // Kill drops the remaining bytes
        if (clear_i) begin
            tf_d = '0;
        end

        // New transfer wins over kill and step
        if (load_i) begin
            tf_d.length = load_len_i;
            tf_d.addr   = load_addr_i;
            tf_d.valid  = 1'b1;
        end
    end

    assign tf_ena = step_i | clear_i | load_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tf_q <= '0;
        end else if (tf_ena) begin
            tf_q <= tf_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            id_q <= id_i;
        end
    end

    // --------------------
    // Burst fields
    // --------------------

    // Beat view with the byte lane cleared
    always_comb begin : proc_align
        aligned_addr               = tf_q.addr;
        aligned_addr.beat.byte_off = '0;
    end

    // Unaligned start adds the leading lanes to the beat count
    assign beat_span = num_bytes + page_len_t'(tf_q.addr.beat.byte_off) - 1'b1;

    assign req_o.id   = id_q;
    assign req_o.addr = aligned_addr;
    assign req_o.len  = beat_span[`LEG_OFFSET_WIDTH +: `LEG_AXI_LEN_WIDTH];

    assign busy_o = tf_q.valid;

    // --------------------
    // Assertions
    // --------------------

    // Splitter and coupler together must keep a burst within 256 beats
    a_len_fits : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        busy_o && (num_bytes != '0) |-> !beat_span[`LEG_PAGE_ADDR_WIDTH])
        else $error("burst len above 255");

    // Coupler may only reload once this side is draining its last burst
    a_load_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        load_i |-> !busy_o || done_o)
        else $error("load while transfer still in flight");

endmodule

`default_nettype wire

// ==== logic/rw_coupler.sv ====
`default_nettype none

module rw_coupler (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    input  wire logic                     valid_i,
    input  wire legalizer_pkg::leg_opt_t  opt_i,
    output logic                          ready_o,
    input  wire logic                     r_ready_i,
    input  wire logic                     w_ready_i,
    input  wire logic                     kill_i,
    input  wire legalizer_pkg::page_len_t r_bytes_to_pb_i,
    input  wire legalizer_pkg::page_len_t w_bytes_to_pb_i,
    input  wire logic                     r_done_i,
    input  wire logic                     w_done_i,
    input  wire logic                     r_busy_i,
    input  wire logic                     w_busy_i,
    output legalizer_pkg::page_len_t      r_bytes_possible_o,
    output legalizer_pkg::page_len_t      w_bytes_possible_o,
    output logic                          step_r_o,
    output logic                          step_w_o,
    output logic                          clear_o,
    output logic                          load_o,
    output logic                          r_valid_o,
    output logic                          w_valid_o,
    output logic                          w_last_o,
    output legalizer_pkg::leg_opt_t       opt_q_o
);
    import legalizer_pkg::*;

    // Options of the active transfer
    leg_opt_t  opt_q;
    // Closer of the two boundaries
    page_len_t c_bytes_to_pb;
    // Per side advance condition
    logic      r_en;
    logic      w_en;

    // --------------------
    // Accept
    // --------------------

    // Next request only once both sides hold their last burst
    assign ready_o = r_done_i & w_done_i & r_ready_i & w_ready_i;
    assign load_o  = ready_o & valid_i;
    assign clear_o = kill_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            opt_q <= '0;
        end else if (load_o) begin
            opt_q <= opt_i;
        end
    end

    assign opt_q_o = opt_q;

    // --------------------
    // Boundaries
    // --------------------
    assign c_bytes_to_pb = (r_bytes_to_pb_i > w_bytes_to_pb_i) ?
                           w_bytes_to_pb_i : r_bytes_to_pb_i;

    // Coupled mode gives both sides the same byte count
    // Decoupled mode keeps each side on its own boundary
    assign r_bytes_possible_o = opt_q.decouple_rw ? r_bytes_to_pb_i : c_bytes_to_pb;
    assign w_bytes_possible_o = opt_q.decouple_rw ? w_bytes_to_pb_i : c_bytes_to_pb;

    // --------------------
    // Flow control
    // --------------------
    always_comb begin : proc_flow
        if (opt_q.decouple_rw) begin
            r_en = r_ready_i;
            w_en = w_ready_i;
        end else begin
            // Either side stalling holds both
            r_en = r_ready_i & w_ready_i;
            w_en = r_ready_i & w_ready_i;
        end
    end

    assign step_r_o = r_en;
    assign step_w_o = w_en;

    // Nothing leaves in the kill cycle
    assign r_valid_o = r_busy_i & r_en & ~kill_i;
    assign w_valid_o = w_busy_i & w_en & ~kill_i;

    // Final write burst of the transfer
    assign w_last_o = w_done_i & w_valid_o;

    // --------------------
    // Assertions
    // --------------------

    // Accept starts both channels on the next cycle
    a_load_start : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        load_o |=> r_busy_i && w_busy_i)
        else $error("accept did not start both channels");

    // Coupled channels stay in lockstep
    a_coupled_sync : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !opt_q.decouple_rw |-> (r_valid_o == w_valid_o))
        else $error("coupled read and write out of step");

endmodule

`default_nettype wire

// ==== logic/legalizer_top.sv ====
`default_nettype none

module legalizer_top (
    input  wire logic                     clk_i,
    input  wire logic                     arst_n_i,
    input  wire legalizer_pkg::leg_req_t  req_i,
    input  wire logic                     valid_i,
    output logic                          ready_o,
    output legalizer_pkg::ax_req_t        r_req_o,
    output logic                          r_valid_o,
    input  wire logic                     r_ready_i,
    output legalizer_pkg::ax_req_t        w_req_o,
    output logic                          w_valid_o,
    input  wire logic                     w_ready_i,
    output logic                          w_last_o,
    input  wire logic                     kill_i,
    output logic                          r_busy_o,
    output logic                          w_busy_o
);
    import legalizer_pkg::*;

    // Registered options
    leg_opt_t  opt_q;

    // Boundary distances and granted byte counts
    page_len_t r_bytes_to_pb;
    page_len_t w_bytes_to_pb;
    page_len_t r_bytes_possible;
    page_len_t w_bytes_possible;

    // Channel status
    logic      r_done;
    logic      w_done;

    // Channel control
    logic      step_r;
    logic      step_w;
    logic      clear;
    logic      load;

    // --------------------
    // Read side
    // --------------------
    burst_channel u_read (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .load_i           (load),
        .step_i           (step_r),
        .clear_i          (clear),
        .load_addr_i      (req_i.src_addr),
        .load_len_i       (req_i.length),
        .id_i             (req_i.id),
        .opt_i            (opt_q.src),
        .bytes_possible_i (r_bytes_possible),
        .bytes_to_pb_o    (r_bytes_to_pb),
        .done_o           (r_done),
        .busy_o           (r_busy_o),
        .req_o            (r_req_o)
    );

    // --------------------
    // Write side
    // --------------------
    burst_channel u_write (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .load_i           (load),
        .step_i           (step_w),
        .clear_i          (clear),
        .load_addr_i      (req_i.dst_addr),
        .load_len_i       (req_i.length),
        .id_i             (req_i.id),
        .opt_i            (opt_q.dst),
        .bytes_possible_i (w_bytes_possible),
        .bytes_to_pb_o    (w_bytes_to_pb),
        .done_o           (w_done),
        .busy_o           (w_busy_o),
        .req_o            (w_req_o)
    );

    // Accept, kill and handshakes for both sides
    rw_coupler u_coupler (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .valid_i            (valid_i),
        .opt_i              (req_i.opt),
        .ready_o            (ready_o),
        .r_ready_i          (r_ready_i),
        .w_ready_i          (w_ready_i),
        .kill_i             (kill_i),
        .r_bytes_to_pb_i    (r_bytes_to_pb),
        .w_bytes_to_pb_i    (w_bytes_to_pb),
        .r_done_i           (r_done),
        .w_done_i           (w_done),
        .r_busy_i           (r_busy_o),
        .w_busy_i           (w_busy_o),
        .r_bytes_possible_o (r_bytes_possible),
        .w_bytes_possible_o (w_bytes_possible),
        .step_r_o           (step_r),
        .step_w_o           (step_w),
        .clear_o            (clear),
        .load_o             (load),
        .r_valid_o          (r_valid_o),
        .w_valid_o          (w_valid_o),
        .w_last_o           (w_last_o),
        .opt_q_o            (opt_q)
    );

endmodule

`default_nettype wire

// ==== bench/legalizer_tb.sv ====
`default_nettype none

`include "legalizer_params.svh"

module legalizer_tb;
    import legalizer_pkg::*;

    // Transfers over all tests set the watchdog limit
    localparam int NUM_XFERS = 44;
    localparam int CLK_PERIOD = 100;

    logic     clk;
    logic     arst_n;
    leg_req_t req_i;
    logic     valid_i;
    logic     ready_o;
    ax_req_t  r_req_o;
    logic     r_valid_o;
    logic     r_ready_i;
    ax_req_t  w_req_o;
    logic     w_valid_o;
    logic     w_ready_i;
    logic     w_last_o;
    logic     kill_i;
    logic     r_busy_o;
    logic     w_busy_o;

    legalizer_top dut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .req_i     (req_i),
        .valid_i   (valid_i),
        .ready_o   (ready_o),
        .r_req_o   (r_req_o),
        .r_valid_o (r_valid_o),
        .r_ready_i (r_ready_i),
        .w_req_o   (w_req_o),
        .w_valid_o (w_valid_o),
        .w_ready_i (w_ready_i),
        .w_last_o  (w_last_o),
        .kill_i    (kill_i),
        .r_busy_o  (r_busy_o),
        .w_busy_o  (w_busy_o)
    );

    // --------------------
    // Clock, LFSR, counters
    // --------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    logic [15:0] lfsr_q = 16'd50205;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       cur_test = "reset";
    // Back-pressure select with bit 0 read and bit 1 write
    logic [1:0]  bp_mode = 2'b00;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic report_value(string what, int exp_v, int act_v);
        errors++;
        $display("** Error %s: %s expected %0d actual %0d", cur_test, what, exp_v, act_v);
    endtask

    task automatic report_text(string what);
        errors++;
        $display("Failure in %s: %s", cur_test, what);
    endtask

    // --------------------
    // Reference model
    // --------------------
    int          m_r_rem;
    int          m_w_rem;
    int          m_r_addr;
    int          m_w_addr;
    leg_opt_t    m_opt;
    logic [3:0]  m_id;
    int          accept_cnt;
    logic        killed_q;
    int          exp_r_bytes;
    int          exp_w_bytes;
    int          exp_r_len;
    int          exp_w_len;

    // Window of one side is a page or the reduced burst size
    function automatic int window(side_opt_t o);
        if (o.reduce_len) begin
            return 4 * (1 << o.max_llen);
        end
        return 1024;
    endfunction

    function automatic logic crosses(int addr, int len, side_opt_t o);
        int last_byte;
        last_byte = addr + (len + 1) * 4 - 1;
        return (addr / window(o)) != (last_byte / window(o));
    endfunction

    always_comb begin
        int br;
        int bw;
        br = window(m_opt.src) - (m_r_addr % window(m_opt.src));
        bw = window(m_opt.dst) - (m_w_addr % window(m_opt.dst));
        // Coupled sides share the closer boundary
        if (!m_opt.decouple_rw) begin
            br = (br < bw) ? br : bw;
            bw = br;
        end
        exp_r_bytes = (m_r_rem < br) ? m_r_rem : br;
        exp_w_bytes = (m_w_rem < bw) ? m_w_rem : bw;
        exp_r_len   = (exp_r_bytes + m_r_addr % 4 - 1) / 4;
        exp_w_len   = (exp_w_bytes + m_w_addr % 4 - 1) / 4;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_r_rem    <= 0;
            m_w_rem    <= 0;
            m_r_addr   <= 0;
            m_w_addr   <= 0;
            m_opt      <= '0;
            m_id       <= '0;
            accept_cnt <= 0;
            killed_q   <= 1'b0;
        end else begin
            killed_q <= kill_i;
            if (r_valid_o) begin
                m_r_addr <= (m_r_addr + exp_r_bytes) % (1 << 24);
                m_r_rem  <= m_r_rem - exp_r_bytes;
            end
            if (w_valid_o) begin
                m_w_addr <= (m_w_addr + exp_w_bytes) % (1 << 24);
                m_w_rem  <= m_w_rem - exp_w_bytes;
            end
            if (kill_i) begin
                m_r_rem <= 0;
                m_w_rem <= 0;
            end
            // New transfer overrides the last burst of the old one
            if (valid_i && ready_o) begin
                m_r_rem    <= int'(req_i.length);
                m_w_rem    <= int'(req_i.length);
                m_r_addr   <= int'(req_i.src_addr);
                m_w_addr   <= int'(req_i.dst_addr);
                m_opt      <= req_i.opt;
                m_id       <= req_i.id;
                accept_cnt <= accept_cnt + 1;
            end
        end
    end

    // --------------------
    // Assertions
    // --------------------
    a_r_addr : assert property (@(posedge clk) disable iff (!arst_n)
        r_valid_o |-> int'(r_req_o.addr) == (m_r_addr & ~3))
        else report_value("read addr", $sampled(m_r_addr) & ~3,
                          int'($sampled(r_req_o.addr)));
    a_r_len : assert property (@(posedge clk) disable iff (!arst_n)
        r_valid_o |-> int'(r_req_o.len) == exp_r_len)
        else report_value("read len", $sampled(exp_r_len), int'($sampled(r_req_o.len)));
    a_w_addr : assert property (@(posedge clk) disable iff (!arst_n)
        w_valid_o |-> int'(w_req_o.addr) == (m_w_addr & ~3))
        else report_value("write addr", $sampled(m_w_addr) & ~3,
                          int'($sampled(w_req_o.addr)));
    a_w_len : assert property (@(posedge clk) disable iff (!arst_n)
        w_valid_o |-> int'(w_req_o.len) == exp_w_len)
        else report_value("write len", $sampled(exp_w_len), int'($sampled(w_req_o.len)));
    a_r_id : assert property (@(posedge clk) disable iff (!arst_n)
        r_valid_o |-> r_req_o.id == m_id)
        else report_value("read id", int'($sampled(m_id)), int'($sampled(r_req_o.id)));
    a_w_id : assert property (@(posedge clk) disable iff (!arst_n)
        w_valid_o |-> w_req_o.id == m_id)
        else report_value("write id", int'($sampled(m_id)), int'($sampled(w_req_o.id)));

    // No burst once every byte of the side went out
    a_no_extra : assert property (@(posedge clk) disable iff (!arst_n)
        (r_valid_o || w_valid_o) |-> (!r_valid_o || m_r_rem > 0) && (!w_valid_o || m_w_rem > 0))
        else report_text("burst emitted after all bytes were sent");

    // Bursts stay inside their page or reduced window
    a_r_no_cross : assert property (@(posedge clk) disable iff (!arst_n)
        r_valid_o |-> !crosses(int'(r_req_o.addr), int'(r_req_o.len), m_opt.src))
        else report_text("a read burst crosses its boundary");
    a_w_no_cross : assert property (@(posedge clk) disable iff (!arst_n)
        w_valid_o |-> !crosses(int'(w_req_o.addr), int'(w_req_o.len), m_opt.dst))
        else report_text("a write burst crosses its boundary");

    a_coupled : assert property (@(posedge clk) disable iff (!arst_n)
        !m_opt.decouple_rw |-> r_valid_o == w_valid_o)
        else report_text("coupled read and write valid differ");

    // Free side keeps going while the other one stalls
    a_decoupled_flow : assert property (@(posedge clk) disable iff (!arst_n)
        m_opt.decouple_rw && !kill_i |->
        (r_busy_o && r_ready_i) == r_valid_o && (w_busy_o && w_ready_i) == w_valid_o)
        else report_text("decoupled side stalled without back-pressure");

    a_last : assert property (@(posedge clk) disable iff (!arst_n)
        w_last_o == (w_valid_o && m_w_rem == exp_w_bytes))
        else report_value("w_last",
                          int'($sampled(w_valid_o) && $sampled(m_w_rem) == $sampled(exp_w_bytes)),
                          int'($sampled(w_last_o)));

    a_accept : assert property (@(posedge clk) disable iff (!arst_n)
        valid_i && ready_o |->
        (m_r_rem == 0 || (r_valid_o && m_r_rem == exp_r_bytes)) &&
        (m_w_rem == 0 || (w_valid_o && m_w_rem == exp_w_bytes)))
        else report_text("request accepted before both sides finished");

    a_kill_quiet : assert property (@(posedge clk) disable iff (!arst_n)
        kill_i |-> !r_valid_o && !w_valid_o)
        else report_text("burst valid in the kill cycle");
    a_kill_idle : assert property (@(posedge clk) disable iff (!arst_n)
        killed_q |-> !r_busy_o && !w_busy_o)
        else report_text("busy still high after kill");

    // --------------------
    // Stimulus
    // --------------------
    always @(negedge clk) begin
        r_ready_i <= bp_mode[0] ? rand_bits(1) : 1'b1;
        w_ready_i <= bp_mode[1] ? rand_bits(1) : 1'b1;
    end

    // Mode 0 is off, 1 on and 2 random
    task automatic send_req(int dec_mode, int red_mode, logic long_xfer);
        int n;
        @(negedge clk);
        req_i.length            = rand_bits(10) + 1;
        req_i.src_addr          = rand_bits(24);
        req_i.dst_addr          = rand_bits(24);
        req_i.id                = rand_bits(4);
        req_i.opt.decouple_rw   = (dec_mode == 2) ? rand_bits(1) : dec_mode[0];
        req_i.opt.src.reduce_len = (red_mode == 2) ? rand_bits(1) : red_mode[0];
        req_i.opt.dst.reduce_len = (red_mode == 2) ? rand_bits(1) : red_mode[0];
        req_i.opt.src.max_llen  = rand_bits(3);
        req_i.opt.dst.max_llen  = rand_bits(3);
        if (long_xfer) begin
            // A full page in single beat windows stays busy for many cycles
            req_i.length           = 1024;
            req_i.opt.src.max_llen = '0;
            req_i.opt.dst.max_llen = '0;
        end
        n       = accept_cnt;
        valid_i = 1'b1;
        while (accept_cnt == n) begin
            @(negedge clk);
        end
        valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (r_busy_o || w_busy_o) begin
            @(negedge clk);
        end
    endtask

    task automatic run_batch(string name, int n, int dec_mode, int red_mode,
                             logic [1:0] bp, logic back_to_back);
        int err_start;
        err_start = errors;
        cur_test  = name;
        bp_mode   = bp;
        for (int i = 0; i < n; i++) begin
            send_req(dec_mode, red_mode, 1'b0);
            if (!back_to_back) begin
                wait_idle();
            end
        end
        wait_idle();
        tests_run++;
        assert (m_r_rem == 0 && m_w_rem == 0)
        else report_value("bytes left", 0, m_r_rem + m_w_rem);
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("test %-14s %s", name, (errors == err_start) ? "passed" : "failed");
    endtask

    task automatic kill_test();
        int err_start;
        err_start = errors;
        cur_test  = "kill";
        bp_mode   = 2'b00;
        send_req(0, 1, 1'b1);
        repeat (3) @(negedge clk);
        kill_i = 1'b1;
        @(negedge clk);
        kill_i = 1'b0;
        wait_idle();
        send_req(2, 2, 1'b0);
        wait_idle();
        tests_run++;
        assert (m_r_rem == 0 && m_w_rem == 0)
        else report_value("bytes left", 0, m_r_rem + m_w_rem);
        if (errors != err_start) begin
            tests_failed++;
        end
        $display("test %-14s %s", "kill", (errors == err_start) ? "passed" : "failed");
    endtask

    initial begin
        arst_n    = 1'b0;
        req_i     = '0;
        valid_i   = 1'b0;
        r_ready_i = 1'b1;
        w_ready_i = 1'b1;
        kill_i    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        run_batch("default_pages", 8, 0, 0, 2'b00, 1'b0);
        run_batch("reduced_len", 8, 2, 1, 2'b00, 1'b0);
        run_batch("coupled", 8, 0, 2, 2'b11, 1'b0);
        run_batch("decoupled_wbp", 5, 1, 2, 2'b10, 1'b0);
        run_batch("decoupled_rbp", 5, 1, 2, 2'b01, 1'b0);
        run_batch("last_overlap", 8, 2, 2, 2'b00, 1'b1);
        kill_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_XFERS * 300 * CLK_PERIOD);
        $display("Timeout: the run did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
logic/legalizer_pkg.sv
logic/page_splitter.sv
logic/burst_channel.sv
logic/rw_coupler.sv
logic/legalizer_top.sv
bench/legalizer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module legalizer_tb -o legalizer_sim \
    && ./obj_dir/legalizer_sim | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
